// File: verilog/frv_macros.svh
`ifndef FRV_MACROS_SVH
`define FRV_MACROS_SVH

// --------------------------------------------------
// Data path widths
// --------------------------------------------------

// Register width, fixed at RV32
`define FRV_XLEN 32

// Opcode field of a request word
`define FRV_OPW 6

// Shift amount, also the grev and shuffle control
`define FRV_SHW 5

`endif

// File: verilog/frv_alu_pkg.sv
`include "frv_macros.svh"

package frv_alu_pkg;

    typedef logic [`FRV_XLEN-1:0] xlen_t;   // One data word
    typedef logic [`FRV_SHW-1:0]  shamt_t;  // Shift amount

    // Encoding order matters, the issue decode shifts a one into this position
    typedef enum logic [`FRV_OPW-1:0] {
        OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND, OP_XNOR, OP_ORN, OP_ANDN,
        OP_SLT, OP_SLTU, OP_MIN, OP_MAX, OP_MINU, OP_MAXU,
        OP_SLL, OP_SRL, OP_SRA, OP_SLO, OP_SRO, OP_ROL, OP_ROR,
        OP_PACK, OP_PACKH, OP_PACKU, OP_GREV, OP_SHFL, OP_UNSHFL,
        OP_CLZ, OP_CTZ, OP_PCNT, OP_SEXTB, OP_SEXTH
    } alu_opcode_e;

    typedef struct packed {
        alu_opcode_e opcode;
        xlen_t       opr_a;
        xlen_t       opr_b;
    } alu_req_t;

    // Declared MSB first, so op_add is bit 0 like OP_ADD
    typedef struct packed {
        logic op_sexth;
        logic op_sextb;
        logic op_pcnt;
        logic op_ctz;
        logic op_clz;
        logic op_unshfl;
        logic op_shfl;
        logic op_grev;
        logic op_packu;
        logic op_packh;
        logic op_pack;
        logic op_ror;
        logic op_rol;
        logic op_sro;
        logic op_slo;
        logic op_sra;
        logic op_srl;
        logic op_sll;
        logic op_maxu;
        logic op_minu;
        logic op_max;
        logic op_min;
        logic op_sltu;
        logic op_slt;
        logic op_andn;
        logic op_orn;
        logic op_xnor;
        logic op_and;
        logic op_or;
        logic op_xor;
        logic op_sub;
        logic op_add;
    } alu_sel_t;

    typedef struct packed {
        alu_sel_t sel;
        xlen_t    opr_a;
        xlen_t    opr_b;
        shamt_t   shamt;
    } alu_issue_t;

    typedef struct packed {
        xlen_t result;
        xlen_t add_out;
        logic  cmp_eq;
        logic  cmp_lt;   // Signed
        logic  cmp_ltu;
    } alu_result_t;

    typedef enum logic [1:0] {
        IDLE,
        OFFER,
        WAIT_DROP
    } wb_state_e;

endpackage

// File: verilog/frv_alu_issue.sv
`timescale 1ns/1ps
`include "frv_macros.svh"

module frv_alu_issue (
    input  logic                    g_clk,
    input  logic                    reset,
    input  logic                    in_req,
    input  frv_alu_pkg::alu_req_t   in_data,
    input  logic                    issue_take,
    output logic                    in_ack,
    output frv_alu_pkg::alu_issue_t issue,
    output logic                    issue_valid
);

    localparam int SELW = $bits(frv_alu_pkg::alu_sel_t);

    logic                  capture;
    frv_alu_pkg::alu_sel_t dec_sel;

    // --------------------------------------------------
    // Opcode decode
    // --------------------------------------------------

    // Unknown opcodes shift the one out and give no select
    assign dec_sel = frv_alu_pkg::alu_sel_t'(SELW'(1) << in_data.opcode);

    // New request only with ack low and the slot empty
    assign capture = in_req && !in_ack && !issue_valid;

    // --------------------------------------------------
    // Handshake and slot control
    // --------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (reset) begin
            in_ack      <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            if (capture) begin
                in_ack <= 1'b1;
            end else if (!in_req) begin
                in_ack <= 1'b0;             // Return to zero
            end

            if (capture) begin
                issue_valid <= 1'b1;
            end else if (issue_take) begin
                issue_valid <= 1'b0;        // Moved on to writeback
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (capture) begin
            issue.sel   <= dec_sel;
            issue.opr_a <= in_data.opr_a;
            issue.opr_b <= in_data.opr_b;
            issue.shamt <= in_data.opr_b[`FRV_SHW-1:0];
        end
    end

    // Ack only answers a request that was already there
    ack_after_req: assert property (
        @(posedge g_clk) disable iff (reset) $rose(in_ack) |-> $past(in_req)
    ) else $error("frv_alu_issue: in_ack rose without in_req");

    sel_onehot: assert property (
        @(posedge g_clk) disable iff (reset) issue_valid |-> $onehot(issue.sel)
    ) else $error("frv_alu_issue: issue selects not one-hot");

endmodule

// File: verilog/frv_alu.sv
`timescale 1ns/1ps
`include "frv_macros.svh"

module frv_alu (
    input  frv_alu_pkg::alu_issue_t  issue,
    output frv_alu_pkg::alu_result_t res
);

    localparam int XL   = `FRV_XLEN - 1;
    localparam int NGRP = 13;   // Result groups on the output mux

    localparam frv_alu_pkg::xlen_t GREV_MASK [5] = '{
        32'h55555555, 32'h33333333, 32'h0F0F0F0F, 32'h00FF00FF, 32'h0000FFFF
    };
    localparam frv_alu_pkg::xlen_t SHFL_ML [4] = '{
        32'h44444444, 32'h30303030, 32'h0F000F00, 32'h00FF0000
    };
    localparam frv_alu_pkg::xlen_t SHFL_MR [4] = '{
        32'h22222222, 32'h0C0C0C0C, 32'h00F000F0, 32'h0000FF00
    };

    frv_alu_pkg::alu_sel_t op;
    frv_alu_pkg::xlen_t    opr_a;
    frv_alu_pkg::xlen_t    opr_b;
    frv_alu_pkg::shamt_t   shamt;

    assign op    = issue.sel;
    assign opr_a = issue.opr_a;
    assign opr_b = issue.opr_b;
    assign shamt = issue.shamt;

    function automatic frv_alu_pkg::xlen_t bit_rev(input frv_alu_pkg::xlen_t x);
        frv_alu_pkg::xlen_t r;
        for (int i = 0; i <= XL; i++) begin
            r[i] = x[XL-i];
        end
        return r;
    endfunction

    // --------------------------------------------------
    // Adder and compares
    // --------------------------------------------------

    frv_alu_pkg::xlen_t addsub_rhs;
    frv_alu_pkg::xlen_t addsub_out;
    logic               lt_s;
    logic               lt_u;
    logic               minmax_lt;
    frv_alu_pkg::xlen_t slt_out;
    frv_alu_pkg::xlen_t min_out;
    frv_alu_pkg::xlen_t max_out;

    assign addsub_rhs = op.op_sub ? ~opr_b : opr_b;    // Two's complement via carry in
    assign addsub_out = opr_a + addsub_rhs + frv_alu_pkg::xlen_t'(op.op_sub);

    assign lt_s = $signed(opr_a) < $signed(opr_b);
    assign lt_u = opr_a < opr_b;

    assign slt_out   = {{XL{1'b0}}, op.op_slt ? lt_s : lt_u};
    assign minmax_lt = (op.op_minu || op.op_maxu) ? lt_u : lt_s;
    assign min_out   = minmax_lt ? opr_a : opr_b;
    assign max_out   = minmax_lt ? opr_b : opr_a;

    // --------------------------------------------------
    // Bitwise, pack and sign extension
    // --------------------------------------------------

    frv_alu_pkg::xlen_t opr_b_n;
    frv_alu_pkg::xlen_t bitw_out;
    frv_alu_pkg::xlen_t pack_out;
    frv_alu_pkg::xlen_t sign_out;

    // Inverted B for the andn, orn and xnor forms
    assign opr_b_n = (op.op_xnor || op.op_orn || op.op_andn) ? ~opr_b : opr_b;

    assign bitw_out = {`FRV_XLEN{op.op_xor || op.op_xnor}} & (opr_a ^ opr_b_n) |
                      {`FRV_XLEN{op.op_or  || op.op_orn }} & (opr_a | opr_b_n) |
                      {`FRV_XLEN{op.op_and || op.op_andn}} & (opr_a & opr_b_n);

    assign pack_out = {`FRV_XLEN{op.op_pack }} & {opr_b[15:0], opr_a[15:0]} |
                      {`FRV_XLEN{op.op_packh}} & {16'b0, opr_b[7:0], opr_a[7:0]} |
                      {`FRV_XLEN{op.op_packu}} & {opr_b[31:16], opr_a[31:16]};

    assign sign_out = op.op_sextb ? {{(XL-7){opr_a[7]}}, opr_a[7:0]} :
                                    {{(XL-15){opr_a[15]}}, opr_a[15:0]};

    // --------------------------------------------------
    // Shifter
    // --------------------------------------------------

    logic                      sh_left;
    logic                      sh_rot;
    logic                      sh_ones;
    frv_alu_pkg::xlen_t        sh_lo;
    frv_alu_pkg::xlen_t        sh_hi;
    logic [2*`FRV_XLEN-1:0]    sh_out;
    frv_alu_pkg::xlen_t        shift_out;

    assign sh_left = op.op_sll || op.op_slo || op.op_rol;
    assign sh_rot  = op.op_rol || op.op_ror;
    assign sh_ones = op.op_slo || op.op_sro;

    // Left shifts run through the right shifter on reversed bits
    assign sh_lo = sh_left ? bit_rev(opr_a) : opr_a;
    assign sh_hi = sh_rot    ? sh_lo                   :
                   sh_ones   ? {`FRV_XLEN{1'b1}}       :
                   op.op_sra ? {`FRV_XLEN{opr_a[XL]}}  :
                               {`FRV_XLEN{1'b0}};

    assign sh_out    = {sh_hi, sh_lo} >> shamt;   // Funnel
    assign shift_out = sh_left ? bit_rev(sh_out[XL:0]) : sh_out[XL:0];

    // --------------------------------------------------
    // Generalized reverse and shuffle
    // --------------------------------------------------

    frv_alu_pkg::xlen_t grev_out;
    frv_alu_pkg::xlen_t shfl_out;
    frv_alu_pkg::xlen_t unshfl_out;

    function automatic frv_alu_pkg::xlen_t grev_step(
        input frv_alu_pkg::xlen_t x,
        input frv_alu_pkg::xlen_t m,
        input int                 n
    );
        return ((x & m) << n) | ((x & ~m) >> n);   // Swap neighbouring blocks of n bits
    endfunction

    function automatic frv_alu_pkg::xlen_t shfl_step(
        input frv_alu_pkg::xlen_t x,
        input frv_alu_pkg::xlen_t ml,
        input frv_alu_pkg::xlen_t mr,
        input int                 n
    );
        return (x & ~(ml | mr)) | ((x << n) & ml) | ((x >> n) & mr);
    endfunction

    always_comb begin
        grev_out   = opr_a;
        shfl_out   = opr_a;
        unshfl_out = opr_a;
        for (int k = 0; k < 5; k++) begin
            if (shamt[k]) begin
                grev_out = grev_step(grev_out, GREV_MASK[k], 1 << k);
            end
        end
        // Shuffle stages run wide to narrow and unshuffle the other way
        for (int k = 3; k >= 0; k--) begin
            if (shamt[k]) begin
                shfl_out = shfl_step(shfl_out, SHFL_ML[k], SHFL_MR[k], 1 << k);
            end
        end
        for (int k = 0; k < 4; k++) begin
            if (shamt[k]) begin
                unshfl_out = shfl_step(unshfl_out, SHFL_ML[k], SHFL_MR[k], 1 << k);
            end
        end
    end

    // --------------------------------------------------
    // Popcount and leading / trailing zeros
    // --------------------------------------------------

    logic [1:0]         pc_s1 [16];
    logic [2:0]         pc_s2 [8];
    logic [3:0]         pc_s3 [4];
    logic [5:0]         pc_cnt;     // Up to 32
    frv_alu_pkg::xlen_t pcnt_out;

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            pc_s1[i] = 2'(opr_a[2*i]) + 2'(opr_a[2*i+1]);
        end
        for (int i = 0; i < 8; i++) begin
            pc_s2[i] = 3'(pc_s1[2*i]) + 3'(pc_s1[2*i+1]);
        end
        for (int i = 0; i < 4; i++) begin
            pc_s3[i] = 4'(pc_s2[2*i]) + 4'(pc_s2[2*i+1]);
        end
        pc_cnt = 6'(pc_s3[0]) + 6'(pc_s3[1]) + 6'(pc_s3[2]) + 6'(pc_s3[3]);
    end

    assign pcnt_out = frv_alu_pkg::xlen_t'(pc_cnt);

    function automatic logic [2:0] clz4(input logic [3:0] b);
        casez (b)
            4'b1???: return 3'd0;
            4'b01??: return 3'd1;
            4'b001?: return 3'd2;
            4'b0001: return 3'd3;
            default: return 3'd4;
        endcase
    endfunction

    function automatic logic [3:0] clz8(input logic [7:0] b);
        logic [2:0] hi;
        hi = clz4(b[7:4]);
        return hi[2] ? 4'd4 + 4'(clz4(b[3:0])) : {1'b0, hi};
    endfunction

    function automatic logic [4:0] clz16(input logic [15:0] b);
        logic [3:0] hi;
        hi = clz8(b[15:8]);
        return hi[3] ? 5'd8 + 5'(clz8(b[7:0])) : {1'b0, hi};
    endfunction

    function automatic logic [5:0] clz32(input logic [31:0] b);
        logic [4:0] hi;
        hi = clz16(b[31:16]);
        return hi[4] ? 6'd16 + 6'(clz16(b[15:0])) : {1'b0, hi};
    endfunction

    frv_alu_pkg::xlen_t cz_in;
    frv_alu_pkg::xlen_t cz_out;

    assign cz_in  = op.op_ctz ? bit_rev(opr_a) : opr_a;   // ctz counts from the reversed word
    assign cz_out = frv_alu_pkg::xlen_t'(clz32(cz_in));

    // --------------------------------------------------
    // Result mux
    // --------------------------------------------------

    logic [NGRP-1:0]    grp;
    frv_alu_pkg::xlen_t grp_out [NGRP-1:0];
    frv_alu_pkg::xlen_t mux_out;

    // Same order in both lists with the highest index first
    assign grp = {
        op.op_sextb || op.op_sexth,
        op.op_pcnt,
        op.op_clz || op.op_ctz,
        op.op_unshfl,
        op.op_shfl,
        op.op_grev,
        op.op_pack || op.op_packh || op.op_packu,
        sh_left || sh_rot || op.op_srl || op.op_sra || op.op_sro,
        op.op_max || op.op_maxu,
        op.op_min || op.op_minu,
        op.op_slt || op.op_sltu,
        op.op_xor || op.op_or || op.op_and || op.op_xnor || op.op_orn || op.op_andn,
        op.op_add || op.op_sub
    };

    assign grp_out = '{
        sign_out, pcnt_out, cz_out, unshfl_out, shfl_out, grev_out, pack_out,
        shift_out, max_out, min_out, slt_out, bitw_out, addsub_out
    };

    always_comb begin
        mux_out = '0;
        for (int g = 0; g < NGRP; g++) begin
            mux_out = mux_out | ({`FRV_XLEN{grp[g]}} & grp_out[g]);
        end
    end

    // Any select must map to exactly one group on the AND-OR mux
    always_comb begin
        grp_single: assert #0 (!(|op) || $onehot(grp))
            else $error("frv_alu: selects do not map to a single result group");
    end

    assign res.result  = mux_out;
    assign res.add_out = addsub_out;
    assign res.cmp_eq  = opr_a == opr_b;
    assign res.cmp_lt  = lt_s;
    assign res.cmp_ltu = lt_u;

endmodule

// File: verilog/frv_alu_writeback.sv
`timescale 1ns/1ps

module frv_alu_writeback (
    input  logic                     g_clk,
    input  logic                     reset,
    input  logic                     issue_valid,
    input  frv_alu_pkg::alu_result_t alu_res,
    input  logic                     out_ack,
    output logic                     issue_take,
    output logic                     out_req,
    output frv_alu_pkg::alu_result_t out_data
);

    frv_alu_pkg::wb_state_e state;

    // Slot empty only in IDLE
    assign issue_take = (state == frv_alu_pkg::IDLE) && issue_valid;

    // --------------------------------------------------
    // Output handshake FSM
    // --------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (reset) begin
            state   <= frv_alu_pkg::IDLE;
            out_req <= 1'b0;
        end else begin
            case (state)
                frv_alu_pkg::IDLE: begin
                    if (issue_valid) begin
                        state   <= frv_alu_pkg::OFFER;
                        out_req <= 1'b1;        // Result lands on this edge
                    end
                end
                frv_alu_pkg::OFFER: begin
                    if (out_ack) begin
                        state   <= frv_alu_pkg::WAIT_DROP;
                        out_req <= 1'b0;
                    end
                end
                frv_alu_pkg::WAIT_DROP: begin
                    // Consumer must release ack before the slot frees
                    if (!out_ack) begin
                        state <= frv_alu_pkg::IDLE;
                    end
                end
                default: begin
                    state   <= frv_alu_pkg::IDLE;
                    out_req <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge g_clk) begin
        if (issue_take) begin
            out_data <= alu_res;
        end
    end

    data_hold: assert property (
        @(posedge g_clk) disable iff (reset)
        out_req && $past(out_req) |-> $stable(out_data)
    ) else $error("frv_alu_writeback: out_data changed while out_req was high");

endmodule

// File: verilog/frv_alu_unit.sv
`timescale 1ns/1ps

module frv_alu_unit (
    input  logic                     g_clk,
    input  logic                     reset,
    input  logic                     in_req,
    input  frv_alu_pkg::alu_req_t    in_data,
    output logic                     in_ack,
    output logic                     out_req,
    output frv_alu_pkg::alu_result_t out_data,
    input  logic                     out_ack
);

    frv_alu_pkg::alu_issue_t  issue;
    logic                     issue_valid;
    logic                     issue_take;
    frv_alu_pkg::alu_result_t alu_res;   // Combinational, sampled by writeback

    frv_alu_issue u_issue (
        .g_clk       (g_clk),
        .reset       (reset),
        .in_req      (in_req),
        .in_data     (in_data),
        .issue_take  (issue_take),
        .in_ack      (in_ack),
        .issue       (issue),
        .issue_valid (issue_valid)
    );

    frv_alu u_alu (
        .issue (issue),
        .res   (alu_res)
    );

    frv_alu_writeback u_writeback (
        .g_clk       (g_clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .alu_res     (alu_res),
        .out_ack     (out_ack),
        .issue_take  (issue_take),
        .out_req     (out_req),
        .out_data    (out_data)
    );

endmodule

// File: sim/tb_frv_alu_ref.svh
`ifndef TB_FRV_ALU_REF_SVH
`define TB_FRV_ALU_REF_SVH

// Bit i moves to bit i ^ ctrl
function automatic frv_alu_pkg::xlen_t generalized_reverse(
    input frv_alu_pkg::xlen_t x,
    input frv_alu_pkg::shamt_t ctrl
);
    frv_alu_pkg::xlen_t r;
    for (int i = 0; i < 32; i++) begin
        r[i ^ int'(ctrl)] = x[i];
    end
    return r;
endfunction

// One shuffle stage swaps index bits k and k+1
function automatic frv_alu_pkg::xlen_t swap_index_bits(
    input frv_alu_pkg::xlen_t x,
    input int k
);
    frv_alu_pkg::xlen_t r;
    int j;
    for (int i = 0; i < 32; i++) begin
        j = i;
        j[k] = i[k+1];
        j[k+1] = i[k];
        r[j] = x[i];
    end
    return r;
endfunction

function automatic frv_alu_pkg::xlen_t shuffle_word(
    input frv_alu_pkg::xlen_t x,
    input frv_alu_pkg::shamt_t ctrl
);
    frv_alu_pkg::xlen_t r;
    r = x;
    for (int k = 3; k >= 0; k--) begin
        if (ctrl[k]) begin
            r = swap_index_bits(r, k);
        end
    end
    return r;
endfunction

function automatic frv_alu_pkg::xlen_t unshuffle_word(
    input frv_alu_pkg::xlen_t x,
    input frv_alu_pkg::shamt_t ctrl
);
    frv_alu_pkg::xlen_t r;
    r = x;
    for (int k = 0; k < 4; k++) begin
        if (ctrl[k]) begin
            r = swap_index_bits(r, k);
        end
    end
    return r;
endfunction

function automatic int count_leading_zeros(input frv_alu_pkg::xlen_t x);
    int n;
    n = 32;
    for (int i = 0; i < 32; i++) begin
        if (x[i]) begin
            n = 31 - i;     // Highest set bit wins
        end
    end
    return n;
endfunction

function automatic int count_trailing_zeros(input frv_alu_pkg::xlen_t x);
    int n;
    n = 32;
    for (int i = 31; i >= 0; i--) begin
        if (x[i]) begin
            n = i;
        end
    end
    return n;
endfunction

function automatic int count_ones(input frv_alu_pkg::xlen_t x);
    int n;
    n = 0;
    for (int i = 0; i < 32; i++) begin
        n += x[i];
    end
    return n;
endfunction

function automatic frv_alu_pkg::xlen_t expected_value(
    input frv_alu_pkg::alu_opcode_e op,
    input frv_alu_pkg::xlen_t a,
    input frv_alu_pkg::xlen_t b
);
    frv_alu_pkg::xlen_t r;
    int sh;
    sh = b[4:0];
    case (op)
        frv_alu_pkg::OP_ADD:    r = a + b;
        frv_alu_pkg::OP_SUB:    r = a - b;
        frv_alu_pkg::OP_XOR:    r = a ^ b;
        frv_alu_pkg::OP_OR:     r = a | b;
        frv_alu_pkg::OP_AND:    r = a & b;
        frv_alu_pkg::OP_XNOR:   r = ~(a ^ b);
        frv_alu_pkg::OP_ORN:    r = a | ~b;
        frv_alu_pkg::OP_ANDN:   r = a & ~b;
        frv_alu_pkg::OP_SLT:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        frv_alu_pkg::OP_SLTU:   r = (a < b) ? 32'd1 : 32'd0;
        frv_alu_pkg::OP_MIN:    r = ($signed(a) < $signed(b)) ? a : b;
        frv_alu_pkg::OP_MAX:    r = ($signed(a) < $signed(b)) ? b : a;
        frv_alu_pkg::OP_MINU:   r = (a < b) ? a : b;
        frv_alu_pkg::OP_MAXU:   r = (a < b) ? b : a;
        frv_alu_pkg::OP_SLL:    r = a << sh;
        frv_alu_pkg::OP_SRL:    r = a >> sh;
        frv_alu_pkg::OP_SRA:    r = $signed(a) >>> sh;
        frv_alu_pkg::OP_SLO:    r = ~(~a << sh);    // Ones shifted in
        frv_alu_pkg::OP_SRO:    r = ~(~a >> sh);
        frv_alu_pkg::OP_ROL:    r = (a << sh) | (a >> (32 - sh));
        frv_alu_pkg::OP_ROR:    r = (a >> sh) | (a << (32 - sh));
        frv_alu_pkg::OP_PACK:   r = {b[15:0], a[15:0]};
        frv_alu_pkg::OP_PACKH:  r = {16'h0000, b[7:0], a[7:0]};
        frv_alu_pkg::OP_PACKU:  r = {b[31:16], a[31:16]};
        frv_alu_pkg::OP_GREV:   r = generalized_reverse(a, b[4:0]);
        frv_alu_pkg::OP_SHFL:   r = shuffle_word(a, b[4:0]);
        frv_alu_pkg::OP_UNSHFL: r = unshuffle_word(a, b[4:0]);
        frv_alu_pkg::OP_CLZ:    r = count_leading_zeros(a);
        frv_alu_pkg::OP_CTZ:    r = count_trailing_zeros(a);
        frv_alu_pkg::OP_PCNT:   r = count_ones(a);
        frv_alu_pkg::OP_SEXTB:  r = {{24{a[7]}}, a[7:0]};
        frv_alu_pkg::OP_SEXTH:  r = {{16{a[15]}}, a[15:0]};
        default:                r = '0;
    endcase
    return r;
endfunction

// Full output record, the adder only subtracts for sub
function automatic frv_alu_pkg::alu_result_t expected_record(
    input frv_alu_pkg::alu_opcode_e op,
    input frv_alu_pkg::xlen_t a,
    input frv_alu_pkg::xlen_t b
);
    frv_alu_pkg::alu_result_t r;
    r.result  = expected_value(op, a, b);
    r.add_out = (op == frv_alu_pkg::OP_SUB) ? a - b : a + b;
    r.cmp_eq  = a == b;
    r.cmp_lt  = $signed(a) < $signed(b);
    r.cmp_ltu = a < b;
    return r;
endfunction

`endif

// File: sim/tb_frv_alu_unit.sv
`timescale 1ns/1ps

module tb_frv_alu_unit;

    localparam int CLK_PERIOD  = 4;
    localparam int N_EDGE      = 14 * 9;    // add..maxu over edge operand pairs
    localparam int N_SHIFT     = 7 * 32;    // Every shift op at every shamt
    localparam int N_BITM      = 11 * 4;
    localparam int N_HOLD      = 6;
    localparam int NUM_REQ     = N_EDGE + N_SHIFT + N_BITM + N_HOLD;
    localparam int WATCHDOG_NS = NUM_REQ * 20 * CLK_PERIOD;

    localparam frv_alu_pkg::xlen_t EDGE_VAL [3] = '{32'h00000000, 32'hffffffff, 32'h80000000};

    logic                     g_clk;
    logic                     reset;
    logic                     in_req;
    frv_alu_pkg::alu_req_t    in_data;
    logic                     in_ack;
    logic                     out_req;
    frv_alu_pkg::alu_result_t out_data;
    logic                     out_ack;

    integer seed;
    int     errors    = 0;
    int     sent      = 0;
    int     accepted  = 0;
    int     received  = 0;
    int     completed = 0;     // Consumer has dropped out_ack
    logic   hold_ack;
    logic   req_seen;
    int     rise_delay [NUM_REQ];
    int     fall_delay [NUM_REQ];

    frv_alu_pkg::alu_result_t exp_q [$];    // Scoreboard in request order
    frv_alu_pkg::alu_opcode_e op_q [$];

    `include "tb_frv_alu_ref.svh"

    frv_alu_unit uut (
        .g_clk    (g_clk),
        .reset    (reset),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    // --------------------------------------------------
    // Protocol checks
    // --------------------------------------------------

    idle_after_reset: assert property (
        @(posedge g_clk) disable iff (reset) !req_seen |-> !in_ack && !out_req
    ) else begin
        errors++;
        $display("in_ack or out_req went high before any request at %0t", $time);
    end

    ack_after_req: assert property (
        @(posedge g_clk) disable iff (reset) $rose(in_ack) |-> $past(in_req)
    ) else begin
        errors++;
        $display("in_ack rose without a pending request at %0t", $time);
    end

    ack_holds: assert property (
        @(posedge g_clk) disable iff (reset) in_req && in_ack |=> in_ack
    ) else begin
        errors++;
        $display("in_ack fell while in_req was still high at %0t", $time);
    end

    ack_drop_after_req: assert property (
        @(posedge g_clk) disable iff (reset) $fell(in_ack) |-> !$past(in_req)
    ) else begin
        errors++;
        $display("in_ack fell before in_req was dropped at %0t", $time);
    end

    req_holds: assert property (
        @(posedge g_clk) disable iff (reset)
        out_req && !out_ack |=> out_req && $stable(out_data)
    ) else begin
        errors++;
        $display("out_req dropped or out_data moved before out_ack at %0t", $time);
    end

    req_drop_after_ack: assert property (
        @(posedge g_clk) disable iff (reset) $fell(out_req) |-> $past(out_ack)
    ) else begin
        errors++;
        $display("out_req fell without out_ack at %0t", $time);
    end

    // Issue slot plus writeback slot
    slots_bounded: assert property (
        @(posedge g_clk) disable iff (reset) accepted - completed <= 2
    ) else begin
        errors++;
        $display("More than two operations accepted and in flight at %0t", $time);
    end

    // --------------------------------------------------
    // Producer and consumer
    // --------------------------------------------------

    task automatic wait_clk();
        @(posedge g_clk);
        #1;
    endtask

    task automatic send_req(
        input frv_alu_pkg::alu_opcode_e op,
        input frv_alu_pkg::xlen_t a,
        input frv_alu_pkg::xlen_t b
    );
        exp_q.push_back(expected_record(op, a, b));
        op_q.push_back(op);
        sent++;
        in_data.opcode = op;
        in_data.opr_a  = a;
        in_data.opr_b  = b;
        in_req   = 1'b1;
        req_seen = 1'b1;
        wait_clk();
        while (!in_ack) begin
            wait_clk();
        end
        accepted++;
        wait_clk();                 // Request stays up for one cycle of ack
        in_req = 1'b0;
        wait_clk();
        while (in_ack) begin
            wait_clk();
        end
    endtask

    task automatic check_result();
        frv_alu_pkg::alu_result_t exp;
        frv_alu_pkg::alu_opcode_e op;
        result_expected: assert (exp_q.size() > 0) else begin
            errors++;
            $display("A result arrived at %0t with no request outstanding", $time);
        end
        if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            op  = op_q.pop_front();
            result_match: assert (out_data === exp) else begin
                errors++;
                $display("Fail %0t: %s gave %h, expected %h", $time, op.name(), out_data, exp);
            end
        end
        received++;
    endtask

    task automatic consume_results();
        int idx;
        forever begin
            wait_clk();
            if (out_req) begin
                check_result();
                idx = (received - 1) % NUM_REQ;
                while (hold_ack) begin
                    wait_clk();
                end
                repeat (rise_delay[idx]) wait_clk();
                out_ack = 1'b1;
                wait_clk();
                while (out_req) begin
                    wait_clk();
                end
                repeat (fall_delay[idx]) wait_clk();
                out_ack = 1'b0;
                completed++;
            end
        end
    endtask

    // --------------------------------------------------
    // Test phases
    // --------------------------------------------------

    task automatic run_edge_ops();
        for (int op = 0; op <= 13; op++) begin
            for (int i = 0; i < 3; i++) begin
                for (int j = 0; j < 3; j++) begin
                    send_req(frv_alu_pkg::alu_opcode_e'(op), EDGE_VAL[i], EDGE_VAL[j]);
                end
            end
        end
    endtask

    task automatic run_shift_ops();
        frv_alu_pkg::xlen_t b;
        for (int op = 14; op <= 20; op++) begin     // sll through ror
            for (int sh = 0; sh < 32; sh++) begin
                b = $random(seed);
                b[4:0] = sh;
                send_req(frv_alu_pkg::alu_opcode_e'(op), $random(seed), b);
            end
        end
    endtask

    task automatic run_bitmanip_ops();
        frv_alu_pkg::xlen_t a;
        for (int op = 21; op <= 31; op++) begin     // pack through sext.h
            for (int rep = 0; rep < 4; rep++) begin
                a = (rep == 0) ? 32'h0 : (rep == 1) ? 32'h00008080 : $random(seed);
                send_req(frv_alu_pkg::alu_opcode_e'(op), a, $random(seed));
            end
        end
    endtask

    // Runs while the consumer sits on out_ack
    task automatic watch_withheld();
        @(posedge g_clk);
        #2;
        while (!(accepted - completed == 2 && in_req && !in_ack)) begin
            @(posedge g_clk);
            #2;
        end
        repeat (8) begin
            @(posedge g_clk);
            #2;
            ack_withheld: assert (!in_ack) else begin
                errors++;
                $display("in_ack was given at %0t with both slots full", $time);
            end
        end
        hold_ack = 1'b0;
    endtask

    task automatic run_hold_phase();
        while (completed != sent) begin
            wait_clk();
        end
        hold_ack = 1'b1;
        fork
            begin
                for (int n = 0; n < N_HOLD; n++) begin
                    send_req(frv_alu_pkg::alu_opcode_e'($unsigned($random(seed)) % 14),
                             $random(seed), $random(seed));
                end
            end
            watch_withheld();
        join
    endtask

    initial begin
        seed     = 32'h08a14688;
        reset    = 1'b1;
        in_req   = 1'b0;
        in_data  = '0;
        out_ack  = 1'b0;
        hold_ack = 1'b0;
        req_seen = 1'b0;
        for (int i = 0; i < NUM_REQ; i++) begin
            rise_delay[i] = $unsigned($random(seed)) % 6;
            fall_delay[i] = $unsigned($random(seed)) % 6;
        end
        repeat (3) @(posedge g_clk);
        #1;
        reset = 1'b0;
        fork
            consume_results();
        join_none
        repeat (3) wait_clk();      // Idle window after reset
        run_edge_ops();
        run_shift_ops();
        run_bitmanip_ops();
        run_hold_phase();
        while (completed != sent) begin
            wait_clk();
        end
        repeat (4) wait_clk();
        all_delivered: assert (received == sent && exp_q.size() == 0) else begin
            errors++;
            $display("Sent %0d requests but received %0d results", sent, received);
        end
        $display("Requests %0d, results %0d, errors %0d", sent, received, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the unit stopped responding", WATCHDOG_NS);
        $display("Requests %0d, results %0d, errors %0d", sent, received, errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: frv_alu_unit.f
+incdir+verilog
+incdir+sim
verilog/frv_alu_pkg.sv
verilog/frv_alu_issue.sv
verilog/frv_alu.sv
verilog/frv_alu_writeback.sv
verilog/frv_alu_unit.sv
sim/tb_frv_alu_unit.sv

// File: Bender.yml
package:
  name: frv_alu_unit

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/frv_alu_pkg.sv
      - verilog/frv_alu_issue.sv
      - verilog/frv_alu.sv
      - verilog/frv_alu_writeback.sv
      - verilog/frv_alu_unit.sv

  - target: simulation
    include_dirs:
      - verilog
      - sim
    files:
      - sim/tb_frv_alu_unit.sv
